/* n_clic_top.f */
source/config_pkg.sv
source/decoder_pkg.sv
source/clic_csr_decode.sv
source/clic_source.sv
source/clic_arbiter.sv
source/n_clic_top.sv
verif/n_clic_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the interrupt controller testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module n_clic_tb -f n_clic_top.f --Mdir obj_dir

output="$(./obj_dir/Vn_clic_tb)"
echo "$output"

if grep -qx "=== PASS ===" <<< "$output"; then
  exit 0
else
  exit 1
fi

/* source/clic_arbiter.sv */
// picks the winning source, compares it with the level, redirects the pc and keeps the return stack
`timescale 1ns/1ps

module clic_arbiter #(
  parameter int NumSources = 8,
  parameter int StackDepth = 7
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [NumSources-1:0]                 req,
  input  config_pkg::PrioT [NumSources-1:0]     prio,
  input  config_pkg::IMemAddrT                  vec_base,
  input  logic                                  ret_strobe,
  input  config_pkg::IMemAddrT                  pc_in,
  output logic [NumSources-1:0]                 take,
  output config_pkg::IMemAddrT                  int_addr,
  output decoder_pkg::pc_interrupt_mux_t        pc_interrupt_sel,
  output config_pkg::PrioT                      level_out,
  output logic                                  interrupt_out
);

  localparam int IdxWidth = (NumSources > 1) ? $clog2(NumSources) : 1;
  localparam int DepthWidth = $clog2(StackDepth + 1);

  logic [IdxWidth-1:0]   win_idx;
  config_pkg::PrioT      win_prio;
  logic                  fire;
  logic                  full;
  logic                  empty;
  logic [DepthWidth-1:0] depth;
  logic [DepthWidth-1:0] top;

  // saved pc and level per nesting step
  config_pkg::IMemAddrT pc_stack  [StackDepth];
  config_pkg::PrioT     lvl_stack [StackDepth];

  // highest priority wins
  // strict compare keeps the lowest index on a tie
  // a request always has nonzero priority, so win_prio stays 0 when idle
  always_comb begin
    win_idx  = '0;
    win_prio = '0;
    for (int i = 0; i < NumSources; i++) begin
      if (req[i] && (prio[i] > win_prio)) begin
        win_idx  = IdxWidth'(i);
        win_prio = prio[i];
      end
    end
  end

  assign full  = (depth == DepthWidth'(StackDepth));
  assign empty = (depth == '0);
  assign top   = empty ? '0 : depth - 1'b1;

  // return has priority over a new take
  assign fire = !ret_strobe && !full && (win_prio > level_out);

  always_comb begin
    for (int i = 0; i < NumSources; i++) begin
      take[i] = fire && (win_idx == IdxWidth'(i));
    end
  end

  assign interrupt_out = fire;
  assign pc_interrupt_sel = (ret_strobe || fire) ? decoder_pkg::PC_INTERRUPT
                                                 : decoder_pkg::PC_NORMAL;

  // one vector word per source
  always_comb begin
    if (ret_strobe) begin
      int_addr = pc_stack[top];
    end else begin
      int_addr = vec_base + config_pkg::IMemAddrT'({win_idx, 2'b00});
    end
  end

  // depth and current level
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      depth     <= '0;
      level_out <= '0;
    end else if (ret_strobe) begin
      if (!empty) begin
        depth     <= depth - 1'b1;
        level_out <= lvl_stack[top];
      end
    end else if (fire) begin
      depth     <= depth + 1'b1;
      level_out <= win_prio;
    end
  end

  // push the interrupted pc and the level it ran at
  always_ff @(posedge clk) begin
    if (fire) begin
      pc_stack[depth]  <= pc_in;
      lvl_stack[depth] <= level_out;
    end
  end

  // every return needs an earlier take still on the stack
  assert property (@(posedge clk) disable iff (!rst_n) ret_strobe |-> !empty)
    else $error("clic_arbiter: return with empty stack");

  // a push grows the stack without wrapping past its depth
  assert property (@(posedge clk) disable iff (!rst_n)
    fire |=> (depth > $past(depth)) && (depth <= DepthWidth'(StackDepth)))
    else $error("clic_arbiter: push into full stack");

  // a take reaches exactly one source
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(take))
    else $error("clic_arbiter: take not one-hot");

endmodule

/* source/clic_csr_decode.sv */
// CSR front end of the interrupt controller: address decode, write value, vector base, read mux
`timescale 1ns/1ps

module clic_csr_decode #(
  parameter int NumSources = 8
) (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            csr_enable,
  input  config_pkg::CsrAddrT                             csr_addr,
  input  decoder_pkg::csr_op_t                            csr_op,
  input  config_pkg::r                                    rs1_zimm,
  input  config_pkg::word                                 rs1_data,
  input  logic [NumSources-1:0][config_pkg::PrioWidth+1:0] src_rdata,
  output config_pkg::word                                 csr_out,
  output logic [NumSources-1:0]                           src_we,
  output logic [config_pkg::PrioWidth+1:0]                src_wdata,
  output config_pkg::IMemAddrT                            vec_base,
  output logic                                            ret_strobe
);

  logic                  hit_base;
  logic                  hit_ret;
  logic [NumSources-1:0] src_sel;
  config_pkg::word       old_val;
  config_pkg::word       operand;
  config_pkg::word       new_val;

  assign hit_base = (csr_addr == config_pkg::ClicBaseAddr);
  assign hit_ret  = (csr_addr == config_pkg::ClicRetAddr);

  // one address compare per source CSR
  always_comb begin
    for (int i = 0; i < NumSources; i++) begin
      src_sel[i] = (csr_addr == config_pkg::CsrAddrT'(config_pkg::ClicSrcBaseAddr + i));
    end
  end

  // old value of the addressed register
  // return address and unmapped CSRs read as zero
  always_comb begin
    old_val = '0;
    if (hit_base) begin
      old_val = 32'(vec_base);
    end
    for (int i = 0; i < NumSources; i++) begin
      if (src_sel[i]) begin
        old_val = 32'(src_rdata[i]);
      end
    end
  end

  assign csr_out = old_val;

  // immediate forms take zimm zero-extended
  always_comb begin
    case (csr_op)
      decoder_pkg::CSRRWI, decoder_pkg::CSRRSI, decoder_pkg::CSRRCI: operand = 32'(rs1_zimm);
      default: operand = rs1_data;
    endcase
  end

  always_comb begin
    case (csr_op)
      decoder_pkg::CSRRW, decoder_pkg::CSRRWI: new_val = operand;
      decoder_pkg::CSRRS, decoder_pkg::CSRRSI: new_val = old_val | operand;
      decoder_pkg::CSRRC, decoder_pkg::CSRRCI: new_val = old_val & ~operand;
      default: new_val = old_val;
    endcase
  end

  // source writes share one data bus
  assign src_we     = src_sel & {NumSources{csr_enable}};
  assign src_wdata  = new_val[config_pkg::PrioWidth+1:0];
  assign ret_strobe = csr_enable & hit_ret;

  // vector table base, low two bits kept zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vec_base <= '0;
    end else if (csr_enable && hit_base) begin
      vec_base <= {new_val[config_pkg::IMemAddrWidth-1:2], 2'b00};
    end
  end

  // source CSR addresses must not alias each other
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(src_we))
    else $error("clic_csr_decode: more than one source CSR written");

endmodule

/* source/clic_source.sv */
// one interrupt source: irq edge detect plus pending, enable and priority CSR state
`timescale 1ns/1ps

module clic_source (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             irq,
  input  logic                             we,
  input  logic [config_pkg::PrioWidth+1:0] wdata,
  input  logic                             take,
  output logic [config_pkg::PrioWidth+1:0] rdata,
  output logic                             req,
  output config_pkg::PrioT                 prio
);

  // irq_s is the current sample, irq_q the one before
  logic irq_s;
  logic irq_q;
  logic irq_rise;
  logic pending;
  logic enable;

  assign irq_rise = irq_s & ~irq_q;

  // write replaces everything, an edge beats a take
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      irq_s   <= 1'b0;
      irq_q   <= 1'b0;
      pending <= 1'b0;
      enable  <= 1'b0;
      prio    <= '0;
    end else begin
      irq_s <= irq;
      irq_q <= irq_s;
      if (we) begin
        pending <= wdata[config_pkg::SrcPendBit];
        enable  <= wdata[config_pkg::SrcEnBit];
        prio    <= wdata[config_pkg::SrcPrioLsb +: config_pkg::PrioWidth];
      end else if (irq_rise) begin
        pending <= 1'b1;
      end else if (take) begin
        pending <= 1'b0;
      end
    end
  end

  always_comb begin
    rdata = '0;
    rdata[config_pkg::SrcPendBit] = pending;
    rdata[config_pkg::SrcEnBit] = enable;
    rdata[config_pkg::SrcPrioLsb +: config_pkg::PrioWidth] = prio;
  end

  // priority 0 never requests
  assign req = pending & enable & (prio != '0);

  // the arbiter may only take a live request
  assert property (@(posedge clk) disable iff (!rst_n) take |-> req)
    else $error("clic_source: take without request");

endmodule

/* source/config_pkg.sv */
// shared sizes, types and CSR map of the interrupt controller, referenced by scoped names
package config_pkg;

  // data path
  typedef logic [31:0] word;

  // instruction address space
  localparam int IMemAddrWidth = 16;
  typedef logic [IMemAddrWidth-1:0] IMemAddrT;

  // instruction fields seen by the controller
  typedef logic [11:0] CsrAddrT;
  typedef logic [4:0] r;

  // priority and level, 0 is idle and never fires
  localparam int PrioWidth = 3;
  typedef logic [PrioWidth-1:0] PrioT;

  // CSR map
  // vector table base, word aligned
  localparam CsrAddrT ClicBaseAddr = 12'hb00;
  // a write here returns from the current interrupt
  localparam CsrAddrT ClicRetAddr = 12'hb01;
  // source i sits at ClicSrcBaseAddr + i
  localparam CsrAddrT ClicSrcBaseAddr = 12'hb10;

  // source CSR layout
  localparam int SrcPendBit = 0;
  localparam int SrcEnBit = 1;
  localparam int SrcPrioLsb = 2;

endpackage

/* source/decoder_pkg.sv */
// encodings shared between the core decoder and the interrupt controller
package decoder_pkg;

  // CSR operations, values follow the funct3 field
  typedef enum logic [2:0] {
    CSRRW  = 3'b001,
    CSRRS  = 3'b010,
    CSRRC  = 3'b011,
    CSRRWI = 3'b101,
    CSRRSI = 3'b110,
    CSRRCI = 3'b111
  } csr_op_t;

  // select of the pc interrupt mux
  typedef enum logic {
    PC_NORMAL    = 1'b0,
    PC_INTERRUPT = 1'b1
  } pc_interrupt_mux_t;

endpackage

/* source/n_clic_top.sv */
// top level of the standalone interrupt controller, CSR decode, sources and arbiter wired together
`timescale 1ns/1ps

module n_clic_top #(
  parameter int NumSources = 8,
  parameter int StackDepth = 7
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [NumSources-1:0]          irq,
  input  logic                           csr_enable,
  input  config_pkg::CsrAddrT            csr_addr,
  input  config_pkg::r                   rs1_zimm,
  input  config_pkg::word                rs1_data,
  input  decoder_pkg::csr_op_t           csr_op,
  input  config_pkg::IMemAddrT           pc_in,
  output config_pkg::word                csr_out,
  output config_pkg::IMemAddrT           int_addr,
  output decoder_pkg::pc_interrupt_mux_t pc_interrupt_sel,
  output config_pkg::PrioT               level_out,
  output logic                           interrupt_out
);

  // decode to sources
  logic [NumSources-1:0]                            src_we;
  logic [config_pkg::PrioWidth+1:0]                 src_wdata;
  logic [NumSources-1:0][config_pkg::PrioWidth+1:0] src_rdata;

  // sources to arbiter and back
  logic [NumSources-1:0]             req;
  config_pkg::PrioT [NumSources-1:0] prio;
  logic [NumSources-1:0]             take;

  // decode to arbiter
  config_pkg::IMemAddrT vec_base;
  logic                 ret_strobe;

  clic_csr_decode #(
    .NumSources(NumSources)
  ) clic_csr_decode (
    .clk,
    .rst_n,
    .csr_enable,
    .csr_addr,
    .csr_op,
    .rs1_zimm,
    .rs1_data,
    .src_rdata,
    .csr_out,
    .src_we,
    .src_wdata,
    .vec_base,
    .ret_strobe
  );

  for (genvar i = 0; i < NumSources; i++) begin : g_src
    clic_source clic_source (
      .clk,
      .rst_n,
      .irq(irq[i]),
      .we(src_we[i]),
      .wdata(src_wdata),
      .take(take[i]),
      .rdata(src_rdata[i]),
      .req(req[i]),
      .prio(prio[i])
    );
  end

  clic_arbiter #(
    .NumSources(NumSources),
    .StackDepth(StackDepth)
  ) clic_arbiter (
    .clk,
    .rst_n,
    .req,
    .prio,
    .vec_base,
    .ret_strobe,
    .pc_in,
    .take,
    .int_addr,
    .pc_interrupt_sel,
    .level_out,
    .interrupt_out
  );

endmodule

/* verif/n_clic_tb.sv */
// directed testbench of the interrupt controller that run.sh builds from n_clic_top.f and runs
`timescale 1ns/1ps

module n_clic_tb;

  localparam int NumSources = 8;
  localparam int StackDepth = 7;
  localparam int NumTests = 5;
  localparam int MaxCyclesPerTest = 200;
  localparam int TimeoutNs = NumTests * MaxCyclesPerTest * 8 * 2;

  logic                           clk;
  logic                           rst_n;
  logic [NumSources-1:0]          irq;
  logic                           csr_enable;
  config_pkg::CsrAddrT            csr_addr;
  config_pkg::r                   rs1_zimm;
  config_pkg::word                rs1_data;
  decoder_pkg::csr_op_t           csr_op;
  config_pkg::IMemAddrT           pc_in;
  config_pkg::word                csr_out;
  config_pkg::IMemAddrT           int_addr;
  decoder_pkg::pc_interrupt_mux_t pc_interrupt_sel;
  config_pkg::PrioT               level_out;
  logic                           interrupt_out;

  int          errors;
  int          checks;
  string       test_name;
  logic [31:0] seed;

  // reference model of the CSRs and the return stack
  config_pkg::IMemAddrT             base_model;
  logic [config_pkg::PrioWidth+1:0] src_model [NumSources];
  config_pkg::IMemAddrT             pc_q [$];
  config_pkg::PrioT                 lvl_q [$];
  config_pkg::PrioT                 level_model;

  n_clic_top #(
    .NumSources(NumSources),
    .StackDepth(StackDepth)
  ) UUT (
    .clk,
    .rst_n,
    .irq,
    .csr_enable,
    .csr_addr,
    .rs1_zimm,
    .rs1_data,
    .csr_op,
    .pc_in,
    .csr_out,
    .int_addr,
    .pc_interrupt_sel,
    .level_out,
    .interrupt_out
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] rand_next();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  task automatic check_word(input string what, input config_pkg::word exp,
                            input config_pkg::word act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: %s expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic check_prio(input string what, input config_pkg::PrioT exp,
                            input config_pkg::PrioT act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: %s expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_sel(input string what, input decoder_pkg::pc_interrupt_mux_t exp,
                           input decoder_pkg::pc_interrupt_mux_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: %s expected %s actual %b", test_name, what, exp.name(), act);
    end
  endtask

  function automatic decoder_pkg::csr_op_t op_of(input int k);
    case (k % 6)
      0: return decoder_pkg::CSRRW;
      1: return decoder_pkg::CSRRS;
      2: return decoder_pkg::CSRRC;
      3: return decoder_pkg::CSRRWI;
      4: return decoder_pkg::CSRRSI;
      default: return decoder_pkg::CSRRCI;
    endcase
  endfunction

  // new CSR value by the op rule with zero-extended immediates
  function automatic config_pkg::word apply_op(input decoder_pkg::csr_op_t op,
      input config_pkg::word old, input config_pkg::word data, input config_pkg::r zimm);
    config_pkg::word operand;
    operand = (op inside {decoder_pkg::CSRRWI, decoder_pkg::CSRRSI, decoder_pkg::CSRRCI})
              ? {27'b0, zimm} : data;
    if (op inside {decoder_pkg::CSRRW, decoder_pkg::CSRRWI}) return operand;
    if (op inside {decoder_pkg::CSRRS, decoder_pkg::CSRRSI}) return old | operand;
    return old & ~operand;
  endfunction

  function automatic config_pkg::CsrAddrT src_addr(input int idx);
    return config_pkg::CsrAddrT'(config_pkg::ClicSrcBaseAddr + idx);
  endfunction

  function automatic logic [config_pkg::PrioWidth+1:0] src_value(input logic en,
      input config_pkg::PrioT p, input logic pend);
    logic [config_pkg::PrioWidth+1:0] v;
    v = '0;
    v[config_pkg::SrcPendBit] = pend;
    v[config_pkg::SrcEnBit] = en;
    v[config_pkg::SrcPrioLsb +: config_pkg::PrioWidth] = p;
    return v;
  endfunction

  task automatic wait_cycle();
    @(negedge clk);
    #1;
  endtask

  // one-cycle CSR access with the old value sampled before the write edge
  task automatic csr_access(input decoder_pkg::csr_op_t op, input config_pkg::CsrAddrT addr,
      input config_pkg::word data, input config_pkg::r zimm, output config_pkg::word old);
    @(negedge clk);
    csr_enable = 1'b1;
    csr_op = op;
    csr_addr = addr;
    rs1_data = data;
    rs1_zimm = zimm;
    #1;
    old = csr_out;
    @(negedge clk);
    csr_enable = 1'b0;
    #1;
  endtask

  task automatic csr_peek(input config_pkg::CsrAddrT addr, output config_pkg::word val);
    @(negedge clk);
    csr_enable = 1'b0;
    csr_addr = addr;
    #1;
    val = csr_out;
  endtask

  task automatic write_source(input int idx, input logic [config_pkg::PrioWidth+1:0] v);
    config_pkg::word old;
    csr_access(decoder_pkg::CSRRW, src_addr(idx), 32'(v), '0, old);
    src_model[idx] = v;
  endtask

  task automatic check_source(input int idx, input logic [config_pkg::PrioWidth+1:0] exp);
    config_pkg::word val;
    csr_peek(src_addr(idx), val);
    check_word($sformatf("source %0d readback", idx), 32'(exp), val);
  endtask

  // irq high for one cycle and back just after the sampling edge
  task automatic pulse_irq(input logic [NumSources-1:0] mask);
    @(negedge clk);
    irq = irq | mask;
    pc_in = config_pkg::IMemAddrT'(rand_next());
    @(negedge clk);
    irq = irq & ~mask;
    #1;
  endtask

  task automatic expect_quiet(input int n);
    repeat (n) begin
      wait_cycle();
      check_bit("interrupt_out idle", 1'b0, interrupt_out);
      check_sel("pc_interrupt_sel idle", decoder_pkg::PC_NORMAL, pc_interrupt_sel);
    end
  endtask

  // called in the cycle of the take
  task automatic expect_take(input int idx, input config_pkg::PrioT p);
    check_bit("interrupt_out on take", 1'b1, interrupt_out);
    check_sel("pc_interrupt_sel on take", decoder_pkg::PC_INTERRUPT, pc_interrupt_sel);
    check_word("vector address", 32'(config_pkg::IMemAddrT'(base_model + 16'(4 * idx))),
               32'(int_addr));
    pc_q.push_back(pc_in);
    lvl_q.push_back(level_model);
    level_model = p;
    wait_cycle();
    check_bit("interrupt_out after take", 1'b0, interrupt_out);
    check_prio("level after take", level_model, level_out);
  endtask

  task automatic do_return();
    config_pkg::IMemAddrT exp_pc;
    config_pkg::PrioT     exp_lvl;
    if (pc_q.size() == 0) begin
      errors++;
      $display("error %s: return requested while the model has no active interrupt", test_name);
      return;
    end
    exp_pc = pc_q.pop_back();
    exp_lvl = lvl_q.pop_back();
    @(negedge clk);
    csr_enable = 1'b1;
    csr_op = decoder_pkg::CSRRW;
    csr_addr = config_pkg::ClicRetAddr;
    rs1_data = rand_next();
    #1;
    check_sel("pc_interrupt_sel on return", decoder_pkg::PC_INTERRUPT, pc_interrupt_sel);
    check_bit("interrupt_out on return", 1'b0, interrupt_out);
    check_word("return address", 32'(exp_pc), 32'(int_addr));
    check_word("return CSR readback", '0, csr_out);
    @(negedge clk);
    csr_enable = 1'b0;
    pc_in = config_pkg::IMemAddrT'(rand_next());
    #1;
    level_model = exp_lvl;
    check_prio("restored level", level_model, level_out);
  endtask

  task automatic test_reset();
    config_pkg::word val;
    test_name = "reset";
    #1;
    check_bit("interrupt_out", 1'b0, interrupt_out);
    check_sel("pc_interrupt_sel", decoder_pkg::PC_NORMAL, pc_interrupt_sel);
    check_prio("level_out", '0, level_out);
    check_word("int_addr", '0, 32'(int_addr));
    csr_peek(config_pkg::ClicBaseAddr, val);
    check_word("base readback", '0, val);
    for (int i = 0; i < NumSources; i++) begin
      check_source(i, '0);
    end
  endtask

  task automatic test_csr_ops();
    config_pkg::word      old;
    config_pkg::word      data;
    config_pkg::word      nv;
    config_pkg::r         zimm;
    decoder_pkg::csr_op_t op;
    int                   idx;
    test_name = "csr_ops";
    for (int k = 0; k < 24; k++) begin
      op = op_of(k / 2);
      data = rand_next();
      zimm = config_pkg::r'(rand_next());
      if (k % 2 == 0) begin
        csr_access(op, config_pkg::ClicBaseAddr, data, zimm, old);
        check_word($sformatf("base old value, %s", op.name()), 32'(base_model), old);
        nv = apply_op(op, 32'(base_model), data, zimm);
        base_model = {nv[config_pkg::IMemAddrWidth-1:2], 2'b00};
      end else begin
        idx = int'(rand_next() % NumSources);
        // pending stays clear so that nothing fires here
        data[config_pkg::SrcPendBit] = 1'b0;
        zimm[config_pkg::SrcPendBit] = 1'b0;
        csr_access(op, src_addr(idx), data, zimm, old);
        check_word($sformatf("source %0d old value, %s", idx, op.name()),
                   32'(src_model[idx]), old);
        nv = apply_op(op, 32'(src_model[idx]), data, zimm);
        src_model[idx] = nv[config_pkg::PrioWidth+1:0];
      end
    end
    csr_peek(config_pkg::ClicBaseAddr, old);
    check_word("base readback", 32'(base_model), old);
    for (int i = 0; i < NumSources; i++) begin
      check_source(i, src_model[i]);
      write_source(i, '0);
    end
    // unmapped CSRs and the return CSR
    csr_access(decoder_pkg::CSRRW, 12'hb08, rand_next(), '0, old);
    check_word("unmapped old value", '0, old);
    csr_peek(12'hb08, old);
    check_word("unmapped readback", '0, old);
    csr_peek(12'h340, old);
    check_word("unmapped readback", '0, old);
    csr_peek(config_pkg::ClicRetAddr, old);
    check_word("return CSR readback", '0, old);
  endtask

  task automatic test_single();
    int               idx;
    config_pkg::PrioT p;
    test_name = "single";
    idx = int'(rand_next() % NumSources);
    p = config_pkg::PrioT'(rand_next() % 7 + 1);
    write_source(idx, src_value(1'b1, p, 1'b0));
    pulse_irq(NumSources'(1) << idx);
    check_bit("interrupt_out before take", 1'b0, interrupt_out);
    wait_cycle();
    expect_take(idx, p);
    check_source(idx, src_value(1'b1, p, 1'b0));
    do_return();
    // disabled source latches pending but stays silent
    idx = int'(rand_next() % NumSources);
    write_source(idx, src_value(1'b0, p, 1'b0));
    pulse_irq(NumSources'(1) << idx);
    expect_quiet(3);
    check_source(idx, src_value(1'b0, p, 1'b1));
    write_source(idx, '0);
    // priority 0 never fires
    idx = int'(rand_next() % NumSources);
    write_source(idx, src_value(1'b1, '0, 1'b0));
    pulse_irq(NumSources'(1) << idx);
    expect_quiet(3);
    check_source(idx, src_value(1'b1, '0, 1'b1));
    write_source(idx, '0);
  endtask

  task automatic test_arbitration();
    int                    idx [4];
    config_pkg::PrioT      prio_of [NumSources];
    logic [NumSources-1:0] pend;
    int                    start;
    int                    best;
    test_name = "arbitration";
    start = int'(rand_next() % NumSources);
    pend = '0;
    for (int k = 0; k < 4; k++) begin
      idx[k] = (start + 3 * k) % NumSources;
      prio_of[idx[k]] = config_pkg::PrioT'(rand_next() % 3 + 1);
    end
    // force one tie
    prio_of[idx[3]] = prio_of[idx[1]];
    for (int k = 0; k < 4; k++) begin
      write_source(idx[k], src_value(1'b1, prio_of[idx[k]], 1'b0));
      pend[idx[k]] = 1'b1;
    end
    pulse_irq(pend);
    wait_cycle();
    for (int k = 0; k < 4; k++) begin
      best = -1;
      for (int i = 0; i < NumSources; i++) begin
        if (pend[i] && (best < 0 || prio_of[i] > prio_of[best])) best = i;
      end
      expect_take(best, prio_of[best]);
      pend[best] = 1'b0;
      expect_quiet(1);
      do_return();
    end
    expect_quiet(2);
    for (int k = 0; k < 4; k++) begin
      write_source(idx[k], '0);
    end
  endtask

  task automatic test_nesting();
    int lo;
    int hi;
    int mid;
    int pl;
    int ph;
    int pm;
    test_name = "nesting";
    lo = int'(rand_next() % NumSources);
    hi = (lo + 3) % NumSources;
    mid = (lo + 5) % NumSources;
    pl = int'(rand_next() % 3) + 2;
    ph = pl + 1 + int'(rand_next() % (7 - pl));
    pm = 1 + int'(rand_next() % pl);
    write_source(lo, src_value(1'b1, config_pkg::PrioT'(pl), 1'b0));
    write_source(hi, src_value(1'b1, config_pkg::PrioT'(ph), 1'b0));
    write_source(mid, src_value(1'b1, config_pkg::PrioT'(pm), 1'b0));
    pulse_irq(NumSources'(1) << lo);
    wait_cycle();
    expect_take(lo, config_pkg::PrioT'(pl));
    // preemption by the higher source
    pulse_irq(NumSources'(1) << hi);
    wait_cycle();
    expect_take(hi, config_pkg::PrioT'(ph));
    pulse_irq(NumSources'(1) << mid);
    expect_quiet(3);
    do_return();
    expect_quiet(2);
    // the held source goes once the level drops to 0
    do_return();
    expect_take(mid, config_pkg::PrioT'(pm));
    do_return();
    expect_quiet(2);
    write_source(lo, '0);
    write_source(hi, '0);
    write_source(mid, '0);
  endtask

  initial begin
    #(TimeoutNs);
    $display("timeout: run did not finish within %0d ns", TimeoutNs);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    irq = '0;
    csr_enable = 1'b0;
    csr_addr = '0;
    rs1_zimm = '0;
    rs1_data = '0;
    csr_op = decoder_pkg::CSRRW;
    pc_in = '0;
    errors = 0;
    checks = 0;
    seed = 32'hd21a_24ea;
    base_model = '0;
    level_model = '0;
    for (int i = 0; i < NumSources; i++) begin
      src_model[i] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_csr_ops();
    test_single();
    test_arbitration();
    test_nesting();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
